// ==== Makefile ====
TOP = spectrum_tb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/spectrum_tb.sv ====
`timescale 1ns/1ns

module spectrum_tb;

  import spectrum_cfg_pkg::*;
  import spectrum_event_pkg::*;

  localparam int W           = 16;
  localparam int BIN_W       = W + GROWTH;             // bits per bin part
  localparam int FRAMES_SENT = 29;                      // all frames over all tests
  localparam int TIMEOUT_CYC = 20 * FRAMES_SENT + 200;

  logic               clk = 1'b0;
  logic               rst_n;
  logic [2*W-1:0]     s_tdata;
  logic               s_tvalid;
  logic               s_tlast;
  logic               s_tready;
  logic [2*BIN_W-1:0] m_tdata;
  logic               m_tvalid;
  logic               m_tlast;
  logic               m_tready;
  event_t             events;

  integer seed;                            // $random state
  int     cyc = 0;                         // posedges since start
  int     err_count = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     test_err_base;
  string  cur_test;

  logic [2*BIN_W-1:0] exp_data [$];        // bins still to come out
  pos_t               exp_idx  [$];

  pos_t   mon_pos;                         // frame position seen on the input
  event_t ev_exp;                          // pulses due next cycle
  int     n_started, n_unexp, n_missing, n_halt; // observed pulse counts
  int     b_started, b_unexp, b_missing, b_halt; // counts at last mark
  int     in_done;                         // frames fully accepted
  int     loads;                           // m_tvalid rises, one per load
  int     last4_edge;                      // edge of last fourth sample
  int     rise_lat;                        // edges from fourth sample to m_tvalid
  int     full_both_cyc;                   // cycles with core and streamer full
  logic   mv_prev;
  bit     bp_done;

  spectrum_top #(.WIDTH(W)) u_spectrum_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_tdata (s_tdata),
    .s_tvalid(s_tvalid),
    .s_tlast (s_tlast),
    .s_tready(s_tready),
    .m_tdata (m_tdata),
    .m_tvalid(m_tvalid),
    .m_tlast (m_tlast),
    .m_tready(m_tready),
    .events  (events)
  );

  always #10 clk = ~clk; // 20 ns period

  // run limit
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: run stopped after %0d cycles with %0d bins still expected",
               cyc, exp_data.size());
      $display("Result: FAILED");
      $finish;
    end
  end

  // DFT by definition, twiddle (-j)^(n*k)
  function automatic logic [2*BIN_W-1:0] ref_bin(input logic [2*W-1:0] x [FRAME_LEN],
                                                 input int k);
    int acc_re;
    int acc_im;
    int re;
    int im;
    logic [BIN_W-1:0] o_re;
    logic [BIN_W-1:0] o_im;
    acc_re = 0;
    acc_im = 0;
    for (int n = 0; n < FRAME_LEN; n++) begin
      re = int'($signed(x[n][W-1:0]));
      im = int'($signed(x[n][2*W-1:W]));
      case ((n * k) % FRAME_LEN)
        0: begin acc_re += re; acc_im += im; end  // times 1
        1: begin acc_re += im; acc_im -= re; end  // times -j
        2: begin acc_re -= re; acc_im -= im; end  // times -1
        default: begin acc_re -= im; acc_im += re; end // times +j
      endcase
    end
    o_re = acc_re[BIN_W-1:0];
    o_im = acc_im[BIN_W-1:0];
    return {o_im, o_re};
  endfunction

  task automatic fail_note(input string what);
    $display("ERROR in %s: %s", cur_test, what);
    err_count++;
  endtask

  task automatic check_bin(input pos_t idx, input logic [2*BIN_W-1:0] got,
                           input logic [2*BIN_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL m_tdata bin %0d: got %h expected %h", idx, got, exp);
      err_count++;
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL m_tlast: got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_events(input event_t got, input event_t exp);
    if (got !== exp) begin
      $display("FAIL events: got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // output, event and back-pressure checks, all at the quiet negedge
  always @(negedge clk) begin
    if (!rst_n) begin
      mon_pos = '0;
      ev_exp  = '0;
      mv_prev = 1'b0;
    end else begin
      check_events(events, ev_exp);
      if (events[EV_FRAME_STARTED])    n_started++;
      if (events[EV_TLAST_UNEXPECTED]) n_unexp++;
      if (events[EV_TLAST_MISSING])    n_missing++;
      if (events[EV_CHANNEL_HALT])     n_halt++;
      if (m_tvalid && !mv_prev) begin
        loads++;
        rise_lat = cyc - last4_edge;
      end
      mv_prev = m_tvalid;
      if (m_tvalid && (in_done - loads) > 0) begin  // a frame waits in the core
        full_both_cyc++;
        if (s_tready) fail_note("s_tready high while core and streamer both hold a frame");
      end
      if (m_tvalid && m_tready) begin
        if (exp_data.size() == 0) begin
          fail_note("bin transferred on m_tdata with none expected");
        end else begin
          check_bin(exp_idx[0], m_tdata, exp_data[0]);
          check_last(m_tlast, exp_idx[0] == LAST_POS);
          void'(exp_data.pop_front());
          void'(exp_idx.pop_front());
        end
      end
      // pulses due after the coming edge
      ev_exp = '0;
      if (s_tvalid && s_tready) begin
        ev_exp[EV_FRAME_STARTED]    = (mon_pos == '0);
        ev_exp[EV_TLAST_UNEXPECTED] = s_tlast && (mon_pos != LAST_POS);
        ev_exp[EV_TLAST_MISSING]    = !s_tlast && (mon_pos == LAST_POS);
        if (mon_pos == LAST_POS) begin
          in_done++;
          last4_edge = cyc + 1;
        end
        mon_pos = mon_pos + 2'd1; // wraps after position 3
      end else if (mon_pos != '0 && s_tready) begin
        ev_exp[EV_CHANNEL_HALT] = 1'b1; // gap inside a frame
      end
    end
  end

  task automatic push_bin(input pos_t idx, input logic [2*BIN_W-1:0] d);
    exp_data.push_back(d);
    exp_idx.push_back(idx);
  endtask

  task automatic expect_frame(input logic [2*W-1:0] x [FRAME_LEN]);
    for (int k = 0; k < FRAME_LEN; k++) begin
      push_bin(pos_t'(k), ref_bin(x, k));
    end
  endtask

  // starts and ends 2 ns after a rising edge
  task automatic send_frame(input logic [2*W-1:0] x [FRAME_LEN], input logic [3:0] lasts,
                            input int gap_after, input int gap_len);
    for (int n = 0; n < FRAME_LEN; n++) begin
      s_tdata  = x[n];
      s_tlast  = lasts[n];
      s_tvalid = 1'b1;
      @(negedge clk);
      while (!s_tready) @(negedge clk);
      @(posedge clk);  // transfer edge
      #2;
      if (n == gap_after && gap_len > 0) begin
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        repeat (gap_len) @(posedge clk);
        #2;
      end
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic settle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(posedge clk);
      #2;
    end
    settle(2);
  endtask

  task automatic mark_events();
    b_started = n_started;
    b_unexp   = n_unexp;
    b_missing = n_missing;
    b_halt    = n_halt;
  endtask

  task automatic check_event_counts(input int fs, input int tu, input int tm, input int h);
    check_count("frame_started pulses", n_started - b_started, fs);
    check_count("tlast_unexpected pulses", n_unexp - b_unexp, tu);
    check_count("tlast_missing pulses", n_missing - b_missing, tm);
    check_count("channel_halt pulses", n_halt - b_halt, h);
  endtask

  task automatic test_begin(input string name);
    cur_test      = name;
    test_err_base = err_count;
  endtask

  task automatic test_end();
    if (err_count == test_err_base) begin
      $display("test %s: passed", cur_test);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", cur_test, err_count - test_err_base);
      tests_failed++;
    end
  endtask

  task automatic test_known_values();
    logic [2*W-1:0] x [FRAME_LEN];
    test_begin("known values");
    x = '{32'h0000_0001, 32'h0, 32'h0, 32'h0}; // impulse, flat spectrum
    for (int k = 0; k < FRAME_LEN; k++) push_bin(pos_t'(k), 36'h0_0000_0001);
    send_frame(x, 4'b1000, -1, 0);
    wait_drain();
    check_count("m_tvalid delay after fourth sample", rise_lat, 2);
    x = '{default: 32'h0000_0001};             // constant, all energy in bin 0
    push_bin(2'd0, 36'h0_0000_0004);
    push_bin(2'd1, 36'h0);
    push_bin(2'd2, 36'h0);
    push_bin(2'd3, 36'h0);
    send_frame(x, 4'b1000, -1, 0);
    wait_drain();
    check_count("m_tvalid delay after fourth sample", rise_lat, 2);
    test_end();
  endtask

  task automatic test_framing();
    logic [2*W-1:0] x [FRAME_LEN];
    test_begin("framing events");
    for (int n = 0; n < FRAME_LEN; n++) x[n] = $random(seed);
    mark_events();
    expect_frame(x);
    send_frame(x, 4'b1010, -1, 0);             // early last on sample 1
    settle(2);
    check_event_counts(1, 1, 0, 0);
    for (int n = 0; n < FRAME_LEN; n++) x[n] = $random(seed);
    mark_events();
    expect_frame(x);
    send_frame(x, 4'b0000, -1, 0);             // never marked
    settle(2);
    check_event_counts(1, 0, 1, 0);
    wait_drain();
    test_end();
  endtask

  task automatic test_halt();
    logic [2*W-1:0] x [FRAME_LEN];
    test_begin("channel halt");
    for (int n = 0; n < FRAME_LEN; n++) x[n] = $random(seed);
    mark_events();
    expect_frame(x);
    send_frame(x, 4'b1000, 1, 3);              // 3 idle cycles after sample 1
    settle(4);                                 // idle between frames
    check_event_counts(1, 0, 0, 3);
    for (int n = 0; n < FRAME_LEN; n++) x[n] = $random(seed);
    expect_frame(x);
    send_frame(x, 4'b1000, -1, 0);
    wait_drain();
    check_event_counts(2, 0, 0, 3);
    test_end();
  endtask

  task automatic test_backpressure();
    logic [2*W-1:0] frames [3][FRAME_LEN];
    logic [2*W-1:0] x [FRAME_LEN];
    int base_full;
    int r;
    test_begin("back-pressure");
    for (int f = 0; f < 3; f++) begin
      for (int n = 0; n < FRAME_LEN; n++) frames[f][n] = $random(seed);
    end
    base_full = full_both_cyc;
    bp_done   = 1'b0;
    fork
      begin
        for (int f = 0; f < 3; f++) begin
          x = frames[f];
          expect_frame(x);
          send_frame(x, 4'b1000, -1, 0);
        end
        wait_drain();
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(posedge clk);
          #2;
          r = $random(seed);
          m_tready = r[0];
        end
      end
    join
    m_tready = 1'b1;
    if (full_both_cyc == base_full) fail_note("core and streamer were never full together");
    test_end();
  endtask

  task automatic test_random();
    logic [2*W-1:0] x [FRAME_LEN];
    test_begin("random throughput");
    for (int f = 0; f < 20; f++) begin
      for (int n = 0; n < FRAME_LEN; n++) begin
        case (f)
          0: x[n] = 32'h8000_8000;             // most negative, bin 0 at the limit
          1: x[n] = 32'h7fff_7fff;
          2: x[n] = (n % 2 == 1) ? 32'h7fff_8000 : 32'h8000_7fff;
          default: x[n] = $random(seed);
        endcase
      end
      expect_frame(x);
      send_frame(x, 4'b1000, -1, 0);
    end
    wait_drain();
    test_end();
  endtask

  initial begin
    seed          = 83;
    rst_n         = 1'b0;
    s_tdata       = '0;
    s_tvalid      = 1'b0;
    s_tlast       = 1'b0;
    m_tready      = 1'b1;
    n_started     = 0;
    n_unexp       = 0;
    n_missing     = 0;
    n_halt        = 0;
    in_done       = 0;
    loads         = 0;
    last4_edge    = 0;
    rise_lat      = 0;
    full_both_cyc = 0;
    bp_done       = 1'b0;
    cur_test      = "reset";
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    settle(2);
    test_known_values();
    test_framing();
    test_halt();
    test_backpressure();
    test_random();
    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/bin_streamer.sv ====
`timescale 1ns/1ns

module bin_streamer #(
  parameter int WIDTH = spectrum_cfg_pkg::SAMPLE_W
) (
  input  logic clk,
  input  logic rst_n,
  // parallel load from the core
  input  logic [spectrum_cfg_pkg::FRAME_LEN*2*(WIDTH+spectrum_cfg_pkg::GROWTH)-1:0] bins_data,
  input  logic bins_valid,
  output logic bins_take,
  // output stream, {im, re}
  output logic [2*(WIDTH+spectrum_cfg_pkg::GROWTH)-1:0] m_tdata,
  output logic m_tvalid,
  output logic m_tlast,
  input  logic m_tready
);

  import spectrum_cfg_pkg::*;

  localparam int BIN_W = WIDTH + GROWTH; // bits per bin part

  logic [2*BIN_W-1:0] buf_q [FRAME_LEN]; // bin buffer
  pos_t               rd_idx;            // next bin to send
  logic               full_q;            // buffer holds a frame
  logic               xfer;              // output handshake

  // load only into an empty buffer
  assign bins_take = bins_valid & ~full_q;
  assign xfer      = full_q & m_tready;

  assign m_tvalid = full_q;
  assign m_tdata  = buf_q[rd_idx];
  assign m_tlast  = full_q & (rd_idx == LAST_POS); // marks bin 3

  // fill flag and read index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      rd_idx <= '0;
    end else if (bins_take) begin
      full_q <= 1'b1;
      rd_idx <= '0;
    end else if (xfer) begin
      if (rd_idx == LAST_POS) begin
        full_q <= 1'b0; // drained, next load allowed
        rd_idx <= '0;
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  // copy all four bins on the take pulse
  always_ff @(posedge clk) begin
    if (bins_take) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        buf_q[i] <= bins_data[i*2*BIN_W +: 2*BIN_W];
      end
    end
  end

endmodule

// ==== logic/dft4_core.sv ====
`timescale 1ns/1ns

module dft4_core #(
  parameter int WIDTH = spectrum_cfg_pkg::SAMPLE_W
) (
  input  logic clk,
  input  logic rst_n,
  // samples in, {im, re}
  input  logic [2*WIDTH-1:0] smp_data,
  input  logic               smp_valid,
  output logic               smp_ready,
  // four bins, bin 0 in the low bits
  output logic [spectrum_cfg_pkg::FRAME_LEN*2*(WIDTH+spectrum_cfg_pkg::GROWTH)-1:0] bins_data,
  output logic               bins_valid,
  input  logic               bins_take
);

  import spectrum_cfg_pkg::*;

  localparam int BIN_W = WIDTH + GROWTH; // bits per bin part

  typedef enum logic [1:0] {
    ST_COLLECT,  // taking samples
    ST_COMPUTE,  // frame complete, bins registered at end of cycle
    ST_HOLD      // bins waiting for the streamer
  } state_t;

  state_t            state_q;
  pos_t              wr_pos;                 // next sample slot
  logic              accept;                 // sample handshake
  logic [2*WIDTH-1:0] smp_q   [FRAME_LEN];   // sample register file
  logic [2*BIN_W-1:0] bins_q  [FRAME_LEN];   // registered bins, {im, re}
  logic signed [BIN_W-1:0] x_re [FRAME_LEN]; // sign-extended parts
  logic signed [BIN_W-1:0] x_im [FRAME_LEN];
  logic signed [BIN_W-1:0] s02_re, s02_im;   // x0 + x2
  logic signed [BIN_W-1:0] s13_re, s13_im;   // x1 + x3
  logic signed [BIN_W-1:0] d02_re, d02_im;   // x0 - x2
  logic signed [BIN_W-1:0] d13_re, d13_im;   // x1 - x3
  logic [2*BIN_W-1:0] bin_d   [FRAME_LEN];   // bins before the register

  assign smp_ready  = (state_q == ST_COLLECT);
  assign bins_valid = (state_q == ST_HOLD);
  assign accept     = smp_valid & smp_ready;

  // control: collect, compute, hold until taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_COLLECT;
      wr_pos  <= '0;
    end else begin
      case (state_q)
        ST_COLLECT: begin
          if (accept) begin
            if (wr_pos == LAST_POS) begin
              wr_pos  <= '0;
              state_q <= ST_COMPUTE;
            end else begin
              wr_pos <= wr_pos + 1'b1;
            end
          end
        end
        ST_COMPUTE: state_q <= ST_HOLD;
        ST_HOLD:    if (bins_take) state_q <= ST_COLLECT; // ready again next cycle
        default:    state_q <= ST_COLLECT;
      endcase
    end
  end

  // sample storage
  always_ff @(posedge clk) begin
    if (accept) smp_q[wr_pos] <= smp_data;
  end

  // unpack and sign-extend to bin width
  always_comb begin
    for (int i = 0; i < FRAME_LEN; i++) begin
      x_re[i] = BIN_W'($signed(smp_q[i][WIDTH-1:0]));
      x_im[i] = BIN_W'($signed(smp_q[i][2*WIDTH-1:WIDTH]));
    end
  end

  // first butterfly stage
  assign s02_re = x_re[0] + x_re[2];
  assign s02_im = x_im[0] + x_im[2];
  assign s13_re = x_re[1] + x_re[3];
  assign s13_im = x_im[1] + x_im[3];
  assign d02_re = x_re[0] - x_re[2];
  assign d02_im = x_im[0] - x_im[2];
  assign d13_re = x_re[1] - x_re[3];
  assign d13_im = x_im[1] - x_im[3];

  // second stage, twiddles are +-1 and +-j only
  assign bin_d[0] = {s02_im + s13_im, s02_re + s13_re};
  assign bin_d[2] = {s02_im - s13_im, s02_re - s13_re};
  assign bin_d[1] = {d02_im - d13_re, d02_re + d13_im}; // -j * d13
  assign bin_d[3] = {d02_im + d13_re, d02_re - d13_im}; // +j * d13

  // bin registers, loaded once per frame
  always_ff @(posedge clk) begin
    if (state_q == ST_COMPUTE) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        bins_q[i] <= bin_d[i];
      end
    end
  end

  // pack in bin order
  always_comb begin
    for (int i = 0; i < FRAME_LEN; i++) begin
      bins_data[i*2*BIN_W +: 2*BIN_W] = bins_q[i];
    end
  end

endmodule

// ==== logic/frame_checker.sv ====
`timescale 1ns/1ns

module frame_checker #(
  parameter int WIDTH = spectrum_cfg_pkg::SAMPLE_W
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // input stream, {im, re}
  input  logic [2*WIDTH-1:0]           s_tdata,
  input  logic                         s_tvalid,
  input  logic                         s_tlast,
  output logic                         s_tready,
  // samples toward the core
  output logic [2*WIDTH-1:0]           smp_data,
  output logic                         smp_valid,
  input  logic                         smp_ready,
  // framing events
  output spectrum_event_pkg::event_t   events
);

  import spectrum_cfg_pkg::*;
  import spectrum_event_pkg::*;

  pos_t   pos_q;   // position of the next sample in the frame
  logic   xfer;    // input handshake this cycle
  logic   in_frame; // frame opened, not all samples seen yet
  event_t ev_d;    // event conditions, this cycle
  event_t ev_q;    // registered pulses

  // data and ready go straight through
  assign smp_data  = s_tdata;
  assign smp_valid = s_tvalid;
  assign s_tready  = smp_ready;

  assign xfer     = s_tvalid & smp_ready;
  assign in_frame = (pos_q != '0);

  // sample counter, frame closes after FRAME_LEN samples
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_q <= '0;
    end else if (xfer) begin
      if (pos_q == LAST_POS) begin
        pos_q <= '0; // s_tlast is not used to close
      end else begin
        pos_q <= pos_q + 1'b1;
      end
    end
  end

  // event conditions from counter and last marker
  always_comb begin
    ev_d = '0;
    ev_d[EV_FRAME_STARTED]    = xfer & (pos_q == '0);
    ev_d[EV_TLAST_UNEXPECTED] = xfer & s_tlast & (pos_q != LAST_POS);
    ev_d[EV_TLAST_MISSING]    = xfer & ~s_tlast & (pos_q == LAST_POS);
    ev_d[EV_CHANNEL_HALT]     = in_frame & smp_ready & ~s_tvalid; // starved, not stalled
  end

  // pulses show one cycle after the cause
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ev_q <= '0;
    end else begin
      ev_q <= ev_d;
    end
  end

  assign events = ev_q;

endmodule

// ==== logic/spectrum_cfg_pkg.sv ====
package spectrum_cfg_pkg;

  // default bits per real or imaginary part of a sample
  localparam int SAMPLE_W = 16;

  // samples per frame, fixed for the radix-4 kernel
  localparam int FRAME_LEN = 4;

  // growth of a four-term sum: log2 of FRAME_LEN
  localparam int GROWTH = 2;

  // width of a sample or bin index
  localparam int POS_W = $clog2(FRAME_LEN);

  // index of a sample or bin within a frame
  typedef logic [POS_W-1:0] pos_t;

  // position of the final sample or bin
  localparam pos_t LAST_POS = pos_t'(FRAME_LEN - 1);

endpackage

// ==== logic/spectrum_event_pkg.sv ====
package spectrum_event_pkg;

  // number of framing event flags
  localparam int EV_COUNT = 4;

  // bit positions inside event_t
  localparam int EV_FRAME_STARTED    = 0; // first sample of a frame accepted
  localparam int EV_TLAST_UNEXPECTED = 1; // last seen before position 3
  localparam int EV_TLAST_MISSING    = 2; // no last on position 3
  localparam int EV_CHANNEL_HALT     = 3; // input gap inside a frame

  // one-cycle pulses, one bit per event
  typedef logic [EV_COUNT-1:0] event_t;

endpackage

// ==== logic/spectrum_top.sv ====
`timescale 1ns/1ns

module spectrum_top #(
  parameter int WIDTH = spectrum_cfg_pkg::SAMPLE_W
) (
  input  logic clk,
  input  logic rst_n,
  // sample stream in, {im, re}
  input  logic [2*WIDTH-1:0] s_tdata,
  input  logic s_tvalid,
  input  logic s_tlast,
  output logic s_tready,
  // bin stream out, {im, re}
  output logic [2*(WIDTH+spectrum_cfg_pkg::GROWTH)-1:0] m_tdata,
  output logic m_tvalid,
  output logic m_tlast,
  input  logic m_tready,
  // framing event pulses
  output spectrum_event_pkg::event_t events
);

  import spectrum_cfg_pkg::*;

  logic [2*WIDTH-1:0]                  smp_data;   // checker to core
  logic                                smp_valid;
  logic                                smp_ready;
  logic [FRAME_LEN*2*(WIDTH+GROWTH)-1:0] bins_data; // core to streamer
  logic                                bins_valid;
  logic                                bins_take;

  frame_checker #(.WIDTH(WIDTH)) u_frame_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .smp_data (smp_data),
    .smp_valid(smp_valid),
    .smp_ready(smp_ready),
    .events   (events)
  );

  dft4_core #(.WIDTH(WIDTH)) u_dft4_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .smp_data  (smp_data),
    .smp_valid (smp_valid),
    .smp_ready (smp_ready),
    .bins_data (bins_data),
    .bins_valid(bins_valid),
    .bins_take (bins_take)
  );

  bin_streamer #(.WIDTH(WIDTH)) u_bin_streamer (
    .clk       (clk),
    .rst_n     (rst_n),
    .bins_data (bins_data),
    .bins_valid(bins_valid),
    .bins_take (bins_take),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tlast   (m_tlast),
    .m_tready  (m_tready)
  );

endmodule

// ==== vlog.f ====
logic/spectrum_cfg_pkg.sv
logic/spectrum_event_pkg.sv
logic/frame_checker.sv
logic/dft4_core.sv
logic/bin_streamer.sv
logic/spectrum_top.sv
dv/spectrum_tb.sv
